// File: rtl/sd_config_pkg.sv
/* Filter and system constants for the four-channel sigma-delta demodulator.
   Imported by the stream package and by every RTL module. */
`default_nettype none

package sd_config_pkg;

    //////////////////////////////////////////////////
    // Channel set
    //////////////////////////////////////////////////

    // Number of modulator inputs and filter channels
    localparam int n_channels = 4;
    localparam int chan_id_width = $clog2(n_channels);

    //////////////////////////////////////////////////
    // CIC filter
    //////////////////////////////////////////////////

    // Modulator samples per output sample
    localparam int decimation_ratio = 64;
    localparam int decim_count_width = $clog2(decimation_ratio);
    // Integrator and comb stage count
    localparam int cic_order = 3;
    // Bit growth is order times log2 of the ratio, plus the input bit
    localparam int cic_width = 1 + cic_order * decim_count_width;
    localparam int sample_width = 16;
    // Drop the low bits so full scale lands at 2**15
    localparam int output_shift = cic_width - sample_width;

    //////////////////////////////////////////////////
    // Modulator clock and register bus
    //////////////////////////////////////////////////

    // System clocks per modulator clock period, power of two
    localparam int mod_clock_div = 4;
    localparam int mod_div_width = $clog2(mod_clock_div);
    // Two threshold registers per channel
    localparam int reg_addr_width = $clog2(2 * n_channels);

endpackage

`default_nettype wire

// File: rtl/sd_stream_pkg.sv
/* Beat and threshold types shared by the channels, register file and combiner. */
`default_nettype none

package sd_stream_pkg;

    import sd_config_pkg::*;

    // One output beat, 20 bits, channel id in the top bits
    typedef struct packed {
        logic [chan_id_width-1:0] chan_id;
        // Unsigned filter output
        logic [sample_width-1:0]  sample;
        logic                     above_high;
        logic                     below_low;
    } sd_beat_t;

    // Per-channel limit pair, high half first
    typedef struct packed {
        logic [sample_width-1:0] high;
        logic [sample_width-1:0] low;
    } sd_thresholds_t;

    // Limits of all channels, index is the channel id
    typedef sd_thresholds_t [n_channels-1:0] sd_threshold_array_t;

endpackage

`default_nettype wire

// File: rtl/sd_clock_gen.sv
/* Modulator clock divider with per-sample and decimation strobes.
   A sync pulse restarts both counters so all channels share the same phase. */
`timescale 1ns/1ps
`default_nettype none

module sd_clock_gen import sd_config_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  logic sync,
    output logic mod_clock,
    output logic sample_strobe,
    output logic decim_strobe
);

    // Phase inside one modulator clock period
    logic [mod_div_width-1:0]     div;
    // Samples taken in the current decimation period
    logic [decim_count_width-1:0] sample_count;

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n || sync) begin
            div          <= '0;
            sample_count <= '0;
        end else begin
            // Divider wraps on its own at mod_clock_div
            div <= div + 1'b1;
            if (sample_strobe) begin
                sample_count <= sample_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // High for the second half of the period, low out of reset
    assign mod_clock = div[mod_div_width-1];

    // Pulse in the cycle where mod_clock goes high
    assign sample_strobe = (div == mod_div_width'(mod_clock_div / 2));

    // Last sample of the period closes the decimation window
    assign decim_strobe = sample_strobe &&
                          (sample_count == decim_count_width'(decimation_ratio - 1));

    // Boundary sample is a real modulator sample, taken where mod_clock rises
    a_decim_on_sample: assert property (
        @(posedge clock) disable iff (!rst_n)
        decim_strobe |-> (sample_strobe && mod_clock && !$past(mod_clock))
    ) else $error("decim_strobe away from a mod_clock rising edge");

endmodule

`default_nettype wire

// File: rtl/sd_channel.sv
/* One sigma-delta channel with a CIC3 decimator and a threshold comparator.
   Emits one beat per decimation period, one clock after decim_strobe. */
`timescale 1ns/1ps
`default_nettype none

module sd_channel import sd_config_pkg::*, sd_stream_pkg::*; (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     sync,
    input  logic                     sample_strobe,
    input  logic                     decim_strobe,
    input  logic                     mod_bit,
    input  logic [chan_id_width-1:0] chan_id,
    input  sd_thresholds_t           limits,
    output logic                     result_valid,
    output sd_beat_t                 result
);

    // Integrator state and its next value with the current bit added
    logic [cic_order-1:0][cic_width-1:0] integ;
    logic [cic_order-1:0][cic_width-1:0] integ_next;
    // Delay element of each comb stage
    logic [cic_order-1:0][cic_width-1:0] comb_delay;
    // Comb chain, stage 0 is the last integrator
    logic [cic_order:0][cic_width-1:0]   comb_stage;
    logic [sample_width-1:0]             scaled;
    logic                                above_high;
    logic                                below_low;

    //////////////////////////////////////////////////
    // Integrators at the modulator rate
    //////////////////////////////////////////////////

    always_comb begin
        // Input bit counts as 0 or 1
        integ_next[0] = integ[0] + cic_width'(mod_bit);
        for (int s = 1; s < cic_order; s++) begin
            integ_next[s] = integ[s] + integ_next[s-1];
        end
    end

    //////////////////////////////////////////////////
    // Combs at the decimated rate
    //////////////////////////////////////////////////

    always_comb begin
        // Boundary sample is already in integ_next
        comb_stage[0] = integ_next[cic_order-1];
        for (int s = 0; s < cic_order; s++) begin
            comb_stage[s+1] = comb_stage[s] - comb_delay[s];
        end
    end

    // All arithmetic wraps, the true result always fits in cic_width
    always_ff @(posedge clock) begin
        if (!rst_n || sync) begin
            integ      <= '0;
            comb_delay <= '0;
        end else begin
            if (sample_strobe) begin
                integ <= integ_next;
            end
            if (decim_strobe) begin
                for (int s = 0; s < cic_order; s++) begin
                    comb_delay[s] <= comb_stage[s];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Scaling, compare and result register
    //////////////////////////////////////////////////

    // Keep the top sample_width bits
    assign scaled     = comb_stage[cic_order][cic_width-1:output_shift];
    assign above_high = (scaled > limits.high);
    assign below_low  = (scaled < limits.low);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            // No beat for a period cut short by sync
            result_valid <= decim_strobe && !sync;
        end
    end

    always_ff @(posedge clock) begin
        if (decim_strobe && !sync) begin
            result.chan_id    <= chan_id;
            result.sample     <= scaled;
            result.above_high <= above_high;
            result.below_low  <= below_low;
        end
    end

    // Full scale of the CIC gain maps to 2**15 after the shift
    a_sample_range: assert property (
        @(posedge clock) disable iff (!rst_n || sync)
        decim_strobe |-> (scaled <= sample_width'(2 ** (sample_width - 1)))
    ) else $error("channel %0d sample %0h out of range", chan_id, scaled);

endmodule

`default_nettype wire

// File: rtl/sd_register_file.sv
/* Threshold registers, two per channel, written by a plain strobe.
   Readback is combinational from reg_addr. */
`timescale 1ns/1ps
`default_nettype none

module sd_register_file import sd_config_pkg::*, sd_stream_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      reg_write,
    input  logic [reg_addr_width-1:0] reg_addr,
    input  logic [sample_width-1:0]   reg_wdata,
    output logic [sample_width-1:0]   reg_rdata,
    output sd_threshold_array_t       thresholds
);

    // Address 2n is high, 2n+1 is low of channel n
    logic [chan_id_width-1:0] addr_chan;
    logic                     addr_low;

    assign addr_chan = reg_addr[reg_addr_width-1:1];
    assign addr_low  = reg_addr[0];

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // Flags stay quiet until software sets real limits
            for (int c = 0; c < n_channels; c++) begin
                thresholds[c].high <= '1;
                thresholds[c].low  <= '0;
            end
        end else if (reg_write) begin
            if (addr_low) begin
                thresholds[addr_chan].low <= reg_wdata;
            end else begin
                thresholds[addr_chan].high <= reg_wdata;
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////

    always_comb begin
        if (addr_low) begin
            reg_rdata = thresholds[addr_chan].low;
        end else begin
            reg_rdata = thresholds[addr_chan].high;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sd_stream_combiner.sv
/* Merges the channel results into one valid/ready stream in channel order.
   Each channel has one slot; a result over a full slot sets the sticky overflow. */
`timescale 1ns/1ps
`default_nettype none

module sd_stream_combiner import sd_config_pkg::*, sd_stream_pkg::*; (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [n_channels-1:0]        result_valid,
    input  sd_beat_t [n_channels-1:0]    results,
    output logic                         out_valid,
    input  logic                         out_ready,
    output sd_beat_t                     out_beat,
    output logic                         overflow
);

    // One slot per channel
    sd_beat_t [n_channels-1:0] slot;
    logic [n_channels-1:0]     full;
    // Slot view with this cycle's results merged in
    sd_beat_t [n_channels-1:0] eff_beat;
    logic [n_channels-1:0]     eff_full;
    logic [chan_id_width-1:0]  pick;
    logic [n_channels-1:0]     take_mask;
    logic                      load_out;

    //////////////////////////////////////////////////
    // Slot view and priority pick
    //////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < n_channels; c++) begin
            // New result wins over the old slot contents
            eff_full[c] = full[c] || result_valid[c];
            eff_beat[c] = result_valid[c] ? results[c] : slot[c];
        end
    end

    // Walk down so the lowest pending channel ends up picked
    always_comb begin
        pick = '0;
        for (int c = n_channels - 1; c >= 0; c--) begin
            if (eff_full[c]) begin
                pick = chan_id_width'(c);
            end
        end
    end

    // Output register is free or being drained this cycle
    assign load_out = !out_valid || out_ready;

    always_comb begin
        take_mask = '0;
        if (load_out && (|eff_full)) begin
            take_mask[pick] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Slots and output register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            full      <= '0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            full <= eff_full & ~take_mask;
            if (load_out) begin
                out_valid <= |eff_full;
            end
            // Sticky until reset
            if (|(result_valid & full)) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int c = 0; c < n_channels; c++) begin
            if (result_valid[c]) begin
                slot[c] <= results[c];
            end
        end
        if (load_out) begin
            out_beat <= eff_beat[pick];
        end
    end

    // A stalled beat stays put until it is taken
    a_stall_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("out_beat changed while stalled");

endmodule

`default_nettype wire

// File: rtl/sd_processor.sv
/* Top level of the four-channel sigma-delta demodulator.
   Drives mod_clock to the modulators and streams decimated samples out. */
`timescale 1ns/1ps
`default_nettype none

module sd_processor import sd_config_pkg::*, sd_stream_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      sync,
    input  logic [n_channels-1:0]     mod_data,
    output logic                      mod_clock,
    input  logic                      reg_write,
    input  logic [reg_addr_width-1:0] reg_addr,
    input  logic [sample_width-1:0]   reg_wdata,
    output logic [sample_width-1:0]   reg_rdata,
    output logic                      out_valid,
    input  logic                      out_ready,
    output sd_beat_t                  out_beat,
    output logic                      overflow
);

    logic                      sample_strobe;
    logic                      decim_strobe;
    sd_threshold_array_t       thresholds;
    logic [n_channels-1:0]     result_valid;
    sd_beat_t [n_channels-1:0] results;

    //////////////////////////////////////////////////
    // Clocking and control
    //////////////////////////////////////////////////

    sd_clock_gen u_clock_gen (
        .clock         (clock),
        .rst_n         (rst_n),
        .sync          (sync),
        .mod_clock     (mod_clock),
        .sample_strobe (sample_strobe),
        .decim_strobe  (decim_strobe)
    );

    sd_register_file u_register_file (
        .clock      (clock),
        .rst_n      (rst_n),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .thresholds (thresholds)
    );

    //////////////////////////////////////////////////
    // Filter channels
    //////////////////////////////////////////////////

    // All channels share the strobes, so their results arrive together
    for (genvar g = 0; g < n_channels; g++) begin : g_channel
        sd_channel u_channel (
            .clock         (clock),
            .rst_n         (rst_n),
            .sync          (sync),
            .sample_strobe (sample_strobe),
            .decim_strobe  (decim_strobe),
            .mod_bit       (mod_data[g]),
            .chan_id       (chan_id_width'(g)),
            .limits        (thresholds[g]),
            .result_valid  (result_valid[g]),
            .result        (results[g])
        );
    end

    //////////////////////////////////////////////////
    // Output stream
    //////////////////////////////////////////////////

    sd_stream_combiner u_combiner (
        .clock        (clock),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .results      (results),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_beat     (out_beat),
        .overflow     (overflow)
    );

endmodule

`default_nettype wire

// File: verif/sd_processor_tb.sv
/* Table-driven testbench for the sigma-delta demodulator top level.
   Each row sets patterns and thresholds, pulses sync and checks the settled output stream. */
`timescale 1ns/1ps
`default_nettype none

module sd_processor_tb import sd_config_pkg::*, sd_stream_pkg::*; ();

    localparam int timeout_clocks     = 2000;
    // CIC3 needs three decimation periods to fill
    localparam int settle_results     = 3;
    localparam int checks_per_channel = 2;
    localparam int n_rows             = 4;
    localparam int n_regs             = 2 * n_channels;
    localparam logic [1:0] ready_always = 2'd0;
    localparam logic [1:0] ready_stall  = 2'd1;
    localparam logic [1:0] ready_random = 2'd2;

    // One table row where every array is indexed by channel
    typedef struct packed {
        logic [n_channels-1:0][7:0]              pattern;
        logic [n_channels-1:0][sample_width-1:0] high;
        logic [n_channels-1:0][sample_width-1:0] low;
        logic [1:0]                              ready_mode;
        logic [15:0]                             stall_clocks;
        logic                                    exp_overflow;
    } row_t;

    logic                      clock;
    logic                      rst_n;
    logic                      sync;
    logic [n_channels-1:0]     mod_data;
    logic                      mod_clock;
    logic                      reg_write;
    logic [reg_addr_width-1:0] reg_addr;
    logic [sample_width-1:0]   reg_wdata;
    logic [sample_width-1:0]   reg_rdata;
    logic                      out_valid;
    logic                      out_ready;
    sd_beat_t                  out_beat;
    logic                      overflow;

    row_t                       rows[n_rows];
    string                      row_names[n_rows];
    logic [n_channels-1:0][7:0] cur_pattern;
    // Expected register contents
    logic [sample_width-1:0]    reg_model[n_regs];
    logic [31:0]                lfsr_state;

    sd_processor dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .sync      (sync),
        .mod_data  (mod_data),
        .mod_clock (mod_clock),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .overflow  (overflow)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Modulator model
    //////////////////////////////////////////////////

    // New bit on the falling edge after each mod_clock rise
    initial begin : drive_modulators
        logic       last_mod;
        logic [2:0] phase;
        last_mod = 1'b0;
        phase = 3'd0;
        mod_data = '0;
        forever begin
            @(negedge clock);
            if (mod_clock && !last_mod) begin
                for (int c = 0; c < n_channels; c++) begin
                    mod_data[c] = cur_pattern[c][phase];
                end
                phase = phase + 3'd1;
            end
            last_mod = mod_clock;
        end
    end

    //////////////////////////////////////////////////
    // Reference rules and helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1 and the new bit entering at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Settled CIC output is the full gain times the ones density, then the shift
    function automatic logic [sample_width-1:0] expected_sample(input logic [7:0] pattern);
        int ones;
        ones = 0;
        for (int b = 0; b < 8; b++) begin
            ones += int'(pattern[b]);
        end
        return sample_width'(((decimation_ratio ** cic_order) * ones / 8) >> output_shift);
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            report_failure($sformatf("check %s did not match", name));
        end
    endtask

    task automatic write_reg(input logic [reg_addr_width-1:0] addr,
                             input logic [sample_width-1:0] data);
        @(negedge clock);
        reg_write = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(negedge clock);
        reg_write = 1'b0;
        reg_model[addr] = data;
    endtask

    // Readback is combinational and sampled one clock after the address settles
    task automatic check_registers(input string name);
        for (int a = 0; a < n_regs; a++) begin
            @(negedge clock);
            reg_addr = reg_addr_width'(a);
            @(negedge clock);
            compare($sformatf("%s reg %0d", name, a), 32'(reg_model[a]), 32'(reg_rdata));
        end
    endtask

    task automatic pulse_sync();
        @(negedge clock);
        sync = 1'b1;
        @(negedge clock);
        sync = 1'b0;
    endtask

    // Let beats from before sync leave the combiner
    task automatic drain_stream(input string name);
        int waited;
        waited = 0;
        out_ready = 1'b1;
        @(negedge clock);
        while (out_valid) begin
            @(negedge clock);
            waited++;
            if (waited > timeout_clocks) begin
                report_failure($sformatf("%s: stream never went idle after sync", name));
            end
        end
    endtask

    // Each level of mod_clock lasts two clocks
    task automatic check_mod_clock(input string name);
        logic last;
        int   run;
        int   edges;
        int   waited;
        last = mod_clock;
        run = 0;
        edges = 0;
        waited = 0;
        while (edges < 7) begin
            @(negedge clock);
            waited++;
            run++;
            if (waited > timeout_clocks) begin
                report_failure($sformatf("%s: mod_clock stopped toggling", name));
            end
            if (mod_clock != last) begin
                if (edges > 0) begin
                    compare($sformatf("%s mod_clock half period", name), 32'd2, 32'(run));
                end
                edges++;
                run = 0;
                last = mod_clock;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stream monitor
    //////////////////////////////////////////////////

    task automatic run_stream(input int r);
        int                      seen[n_channels];
        int                      checked[n_channels];
        int                      done_count;
        int                      beat_count;
        int                      waited;
        int                      stall_left;
        int                      ch;
        logic                    stalled;
        sd_beat_t                held;
        logic [sample_width-1:0] exp_sample;
        string                   name;
        name = row_names[r];
        for (int c = 0; c < n_channels; c++) begin
            seen[c] = 0;
            checked[c] = 0;
        end
        done_count = 0;
        beat_count = 0;
        waited = 0;
        stalled = 1'b0;
        held = '0;
        stall_left = (rows[r].ready_mode == ready_stall) ? int'(rows[r].stall_clocks) : 0;
        while (done_count < n_channels) begin
            @(negedge clock);
            waited++;
            if (waited > timeout_clocks) begin
                report_failure($sformatf("%s: stream checks did not finish in time", name));
            end
            // A refused beat must still be offered, unchanged
            if (stalled) begin
                compare($sformatf("%s stalled valid", name), 32'd1, 32'(out_valid));
                compare($sformatf("%s stalled beat", name), 32'(held), 32'(out_beat));
            end
            case (rows[r].ready_mode)
                ready_stall: begin
                    out_ready = (stall_left == 0);
                    if (stall_left > 0) begin
                        stall_left--;
                    end
                end
                ready_random: begin
                    lfsr_state = lfsr_next(lfsr_state);
                    out_ready = lfsr_state[0];
                end
                default: out_ready = 1'b1;
            endcase
            stalled = out_valid && !out_ready;
            held = out_beat;
            if (out_valid && out_ready) begin
                ch = int'(out_beat.chan_id);
                // Order only holds when no slot was overwritten
                if (rows[r].ready_mode != ready_stall) begin
                    compare($sformatf("%s channel order", name),
                            32'(beat_count % n_channels), 32'(ch));
                end
                beat_count++;
                seen[ch]++;
                if (seen[ch] > settle_results && checked[ch] < checks_per_channel) begin
                    exp_sample = expected_sample(rows[r].pattern[ch]);
                    compare($sformatf("%s ch%0d sample", name, ch),
                            32'(exp_sample), 32'(out_beat.sample));
                    compare($sformatf("%s ch%0d above_high", name, ch),
                            32'(exp_sample > rows[r].high[ch]), 32'(out_beat.above_high));
                    compare($sformatf("%s ch%0d below_low", name, ch),
                            32'(exp_sample < rows[r].low[ch]), 32'(out_beat.below_low));
                    checked[ch]++;
                    if (checked[ch] == checks_per_channel) begin
                        done_count++;
                    end
                end
            end
        end
        out_ready = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////

    // Concatenations list channel 3 first
    task automatic load_table();
        row_names[0] = "ramp_low";
        rows[0].pattern = {8'h07, 8'h03, 8'h01, 8'h00};
        rows[0].high = {16'h2ee0, 16'h1f40, 16'h1000, 16'hffff};
        rows[0].low = {16'h32c8, 16'h2000, 16'h1388, 16'h0000};
        rows[0].ready_mode = ready_always;
        rows[0].stall_clocks = 16'd0;
        rows[0].exp_overflow = 1'b0;
        // Random back-pressure is light enough that no slot is overwritten
        row_names[1] = "ramp_high";
        rows[1].pattern = {8'h7f, 8'h3f, 8'h1f, 8'h0f};
        rows[1].high = {16'h7000, 16'hffff, 16'h4fff, 16'h4000};
        rows[1].low = {16'h8000, 16'h6000, 16'h0000, 16'h4001};
        rows[1].ready_mode = ready_random;
        rows[1].stall_clocks = 16'd0;
        rows[1].exp_overflow = 1'b0;
        row_names[2] = "full_scale";
        rows[2].pattern = {8'h00, 8'h81, 8'h55, 8'hff};
        rows[2].high = {16'h0000, 16'h1fff, 16'hffff, 16'h7fff};
        rows[2].low = {16'h0001, 16'h0000, 16'h4000, 16'h0000};
        rows[2].ready_mode = ready_always;
        rows[2].stall_clocks = 16'd0;
        rows[2].exp_overflow = 1'b0;
        // Overflow is sticky, so this row runs last
        row_names[3] = "long_stall";
        rows[3].pattern = {8'h3c, 8'ha5, 8'hee, 8'h11};
        rows[3].high = {16'hffff, 16'hffff, 16'hffff, 16'hffff};
        rows[3].low = {16'h0000, 16'h0000, 16'h0000, 16'h0000};
        rows[3].ready_mode = ready_stall;
        rows[3].stall_clocks = 16'd600;
        rows[3].exp_overflow = 1'b1;
    endtask

    initial begin
        lfsr_state = 32'hcf;
        rst_n = 1'b0;
        sync = 1'b0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        out_ready = 1'b1;
        cur_pattern = '0;
        // High thresholds reset to all ones, low ones to zero
        for (int a = 0; a < n_regs; a++) begin
            if (a % 2 == 0) begin
                reg_model[a] = '1;
            end else begin
                reg_model[a] = '0;
            end
        end
        load_table();
        repeat (16) @(negedge clock);
        // Outputs held low by reset
        compare("reset out_valid", 32'd0, 32'(out_valid));
        compare("reset overflow", 32'd0, 32'(overflow));
        compare("reset mod_clock", 32'd0, 32'(mod_clock));
        rst_n = 1'b1;

        check_registers("reset_values");
        write_reg(reg_addr_width'(5), 16'h1234);
        check_registers("single_write");

        for (int r = 0; r < n_rows; r++) begin
            cur_pattern = rows[r].pattern;
            for (int c = 0; c < n_channels; c++) begin
                write_reg(reg_addr_width'(2 * c), rows[r].high[c]);
                write_reg(reg_addr_width'(2 * c + 1), rows[r].low[c]);
            end
            check_registers(row_names[r]);
            pulse_sync();
            drain_stream(row_names[r]);
            check_mod_clock(row_names[r]);
            run_stream(r);
            compare($sformatf("%s overflow", row_names[r]),
                    32'(rows[r].exp_overflow), 32'(overflow));
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/sd_config_pkg.sv
rtl/sd_stream_pkg.sv
rtl/sd_clock_gen.sv
rtl/sd_channel.sv
rtl/sd_register_file.sv
rtl/sd_stream_combiner.sv
rtl/sd_processor.sv
verif/sd_processor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the demodulator testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module sd_processor_tb -o sd_processor_sim -f all.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sd_processor_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Regression failed" "$sim_log"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
